//--- Bender.yml
package:
  name: hazard_unit

sources:
  - src/hazardPkg.sv
  - src/demandDecoder.sv
  - src/producerDecoder.sv
  - src/stageTracker.sv
  - src/stallControl.sv
  - src/forwardSelect.sv
  - src/hazardUnit.sv
  - target: simulation
    files:
      - verif/hazardUnitTb.sv

//--- src/demandDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module demandDecoder (
	input  wire logic [31:0]     instr,
	output hazardPkg::demandT    demand
);

	logic [5:0] opcode;
	logic [5:0] funct;

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];

	always_comb begin
		// Fields are always passed on, the use bits say whether they matter
		demand        = '0;
		demand.rs     = instr[25:21];
		demand.rt     = instr[20:16];

		case (opcode)
			hazardPkg::opR: begin
				case (funct)
					hazardPkg::fnAdd, hazardPkg::fnSub, hazardPkg::fnAnd,
					hazardPkg::fnOr, hazardPkg::fnSlt, hazardPkg::fnSltu: begin
						demand.useRs  = 1'b1;
						demand.tuseRs = 2'd1;
						demand.useRt  = 1'b1;
						demand.tuseRt = 2'd1;
					end
					// Jump target needed right away in D
					hazardPkg::fnJr: begin
						demand.useRs  = 1'b1;
						demand.tuseRs = 2'd0;
					end
					hazardPkg::fnMult, hazardPkg::fnMultu,
					hazardPkg::fnDiv, hazardPkg::fnDivu: begin
						demand.useRs  = 1'b1;
						demand.tuseRs = 2'd1;
						demand.useRt  = 1'b1;
						demand.tuseRt = 2'd1;
						demand.isMd   = 1'b1;
					end
					hazardPkg::fnMthi, hazardPkg::fnMtlo: begin
						demand.useRs  = 1'b1;
						demand.tuseRs = 2'd1;
						demand.isMd   = 1'b1;
					end
					// HI/LO reads, no GPR source
					hazardPkg::fnMfhi, hazardPkg::fnMflo: begin
						demand.isMd = 1'b1;
					end
					default: ;
				endcase
			end
			hazardPkg::opOri, hazardPkg::opAddi, hazardPkg::opAndi,
			hazardPkg::opLw, hazardPkg::opLb, hazardPkg::opLh,
			hazardPkg::opLwmx: begin
				demand.useRs  = 1'b1;
				demand.tuseRs = 2'd1;
			end
			// Address in E, store data only in M
			hazardPkg::opSw, hazardPkg::opSb, hazardPkg::opSh: begin
				demand.useRs  = 1'b1;
				demand.tuseRs = 2'd1;
				demand.useRt  = 1'b1;
				demand.tuseRt = 2'd2;
			end
			// Compare happens in D
			hazardPkg::opBeq, hazardPkg::opBne: begin
				demand.useRs  = 1'b1;
				demand.tuseRs = 2'd0;
				demand.useRt  = 1'b1;
				demand.tuseRt = 2'd0;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- src/forwardSelect.sv
`timescale 1ns/10ps
`default_nettype none

module forwardSelect (
	input  wire hazardPkg::demandT   demand,
	input  wire hazardPkg::stageRecT recE,
	input  wire hazardPkg::stageRecT recM,
	input  wire hazardPkg::stageRecT recW,
	output hazardPkg::fwdSelT        fwdRsD,
	output hazardPkg::fwdSelT        fwdRtD,
	output hazardPkg::fwdSelT        fwdRsE,
	output hazardPkg::fwdSelT        fwdRtE,
	output hazardPkg::fwdSelT        fwdRtM
);

	hazardPkg::regNumT srcRsD;
	hazardPkg::regNumT srcRtD;

	// Ready value for this source sitting in that stage
	function automatic logic readyHit(
		input hazardPkg::regNumT   src,
		input hazardPkg::producerT prod
	);
		return (src != '0) && (src == prod.dest) && (prod.tnew == 2'd0);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Nearest ready producer wins
	//////////////////////////////////////////////////////////////////////

	assign srcRsD = demand.useRs ? demand.rs : '0;
	assign srcRtD = demand.useRt ? demand.rt : '0;

	always_comb begin
		fwdRsD = hazardPkg::fwdNone;
		if (readyHit(srcRsD, recE.prod))      fwdRsD = hazardPkg::fwdFromE;
		else if (readyHit(srcRsD, recM.prod)) fwdRsD = hazardPkg::fwdFromM;
		else if (readyHit(srcRsD, recW.prod)) fwdRsD = hazardPkg::fwdFromW;

		fwdRtD = hazardPkg::fwdNone;
		if (readyHit(srcRtD, recE.prod))      fwdRtD = hazardPkg::fwdFromE;
		else if (readyHit(srcRtD, recM.prod)) fwdRtD = hazardPkg::fwdFromM;
		else if (readyHit(srcRtD, recW.prod)) fwdRtD = hazardPkg::fwdFromW;

		// E operands only look further down the pipe
		fwdRsE = hazardPkg::fwdNone;
		if (readyHit(recE.srcRs, recM.prod))      fwdRsE = hazardPkg::fwdFromM;
		else if (readyHit(recE.srcRs, recW.prod)) fwdRsE = hazardPkg::fwdFromW;

		fwdRtE = hazardPkg::fwdNone;
		if (readyHit(recE.srcRt, recM.prod))      fwdRtE = hazardPkg::fwdFromM;
		else if (readyHit(recE.srcRt, recW.prod)) fwdRtE = hazardPkg::fwdFromW;

		// Store data in M
		fwdRtM = hazardPkg::fwdNone;
		if (readyHit(recM.srcRt, recW.prod)) fwdRtM = hazardPkg::fwdFromW;
	end

endmodule

`default_nettype wire

//--- src/hazardPkg.sv
`default_nettype none

package hazardPkg;

	//////////////////////////////////////////////////////////////////////
	// Basic widths and types
	//////////////////////////////////////////////////////////////////////

	typedef logic [4:0] regNumT;
	typedef logic [1:0] stageCntT;

	// Link register written by jal
	localparam regNumT regRa = 5'd31;

	//////////////////////////////////////////////////////////////////////
	// Opcodes
	//////////////////////////////////////////////////////////////////////

	localparam logic [5:0] opR    = 6'b000000;
	localparam logic [5:0] opOri  = 6'b001101;
	localparam logic [5:0] opAddi = 6'b001000;
	localparam logic [5:0] opAndi = 6'b001100;
	localparam logic [5:0] opLui  = 6'b001111;
	localparam logic [5:0] opLw   = 6'b100011;
	localparam logic [5:0] opLb   = 6'b100000;
	localparam logic [5:0] opLh   = 6'b100001;
	localparam logic [5:0] opSw   = 6'b101011;
	localparam logic [5:0] opSb   = 6'b101000;
	localparam logic [5:0] opSh   = 6'b101001;
	localparam logic [5:0] opBeq  = 6'b000100;
	localparam logic [5:0] opBne  = 6'b000101;
	localparam logic [5:0] opJ    = 6'b000010;
	localparam logic [5:0] opJal  = 6'b000011;
	// Custom load, result goes to a register picked late
	localparam logic [5:0] opLwmx = 6'b110011;

	//////////////////////////////////////////////////////////////////////
	// Funct codes for opR
	//////////////////////////////////////////////////////////////////////

	localparam logic [5:0] fnAdd   = 6'b100000;
	localparam logic [5:0] fnSub   = 6'b100010;
	localparam logic [5:0] fnAnd   = 6'b100100;
	localparam logic [5:0] fnOr    = 6'b100101;
	localparam logic [5:0] fnSlt   = 6'b101010;
	localparam logic [5:0] fnSltu  = 6'b101011;
	localparam logic [5:0] fnJr    = 6'b001000;
	localparam logic [5:0] fnMult  = 6'b011000;
	localparam logic [5:0] fnMultu = 6'b011001;
	localparam logic [5:0] fnDiv   = 6'b011010;
	localparam logic [5:0] fnDivu  = 6'b011011;
	localparam logic [5:0] fnMfhi  = 6'b010000;
	localparam logic [5:0] fnMflo  = 6'b010010;
	localparam logic [5:0] fnMthi  = 6'b010001;
	localparam logic [5:0] fnMtlo  = 6'b010011;

	//////////////////////////////////////////////////////////////////////
	// Stage records
	//////////////////////////////////////////////////////////////////////

	// dest of 0 means nothing is produced
	typedef struct packed {
		regNumT   dest;
		stageCntT tnew;
	} producerT;

	typedef struct packed {
		regNumT   rs;
		regNumT   rt;
		logic     useRs;
		logic     useRt;
		stageCntT tuseRs;
		stageCntT tuseRt;
		logic     isMd;
	} demandT;

	// Carried through E, M and W
	typedef struct packed {
		producerT prod;
		regNumT   srcRs;
		regNumT   srcRt;
	} stageRecT;

	typedef enum logic [1:0] {
		fwdNone  = 2'b00,
		fwdFromE = 2'b01,
		fwdFromM = 2'b10,
		fwdFromW = 2'b11
	} fwdSelT;

endpackage

`default_nettype wire

//--- src/hazardUnit.sv
`timescale 1ns/10ps
`default_nettype none

module hazardUnit (
	input  wire logic         clk,
	input  wire logic         rstN,
	input  wire logic [31:0]  instrD,
	input  wire logic         mdBusy,
	output logic              stall,
	output hazardPkg::fwdSelT fwdRsD,
	output hazardPkg::fwdSelT fwdRtD,
	output hazardPkg::fwdSelT fwdRsE,
	output hazardPkg::fwdSelT fwdRtE,
	output hazardPkg::fwdSelT fwdRtM
);

	hazardPkg::demandT   demandD;
	hazardPkg::producerT prodD;
	hazardPkg::stageRecT recE;
	hazardPkg::stageRecT recM;
	hazardPkg::stageRecT recW;

	//////////////////////////////////////////////////////////////////////
	// D-stage decode
	//////////////////////////////////////////////////////////////////////

	demandDecoder u_demandDecoder (
		.instr  (instrD),
		.demand (demandD)
	);

	producerDecoder u_producerDecoder (
		.instr (instrD),
		.prod  (prodD)
	);

	// E, M and W bookkeeping
	stageTracker u_stageTracker (
		.clk     (clk),
		.rstN    (rstN),
		.stall   (stall),
		.prodD   (prodD),
		.demandD (demandD),
		.recE    (recE),
		.recM    (recM),
		.recW    (recW)
	);

	stallControl u_stallControl (
		.demand (demandD),
		.prodE  (recE.prod),
		.prodM  (recM.prod),
		.mdBusy (mdBusy),
		.stall  (stall)
	);

	forwardSelect u_forwardSelect (
		.demand (demandD),
		.recE   (recE),
		.recM   (recM),
		.recW   (recW),
		.fwdRsD (fwdRsD),
		.fwdRtD (fwdRtD),
		.fwdRsE (fwdRsE),
		.fwdRtE (fwdRtE),
		.fwdRtM (fwdRtM)
	);

endmodule

`default_nettype wire

//--- src/producerDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module producerDecoder (
	input  wire logic [31:0]     instr,
	output hazardPkg::producerT  prod
);

	logic [5:0]        opcode;
	logic [5:0]        funct;
	hazardPkg::regNumT rt;
	hazardPkg::regNumT rd;

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];

	//////////////////////////////////////////////////////////////////////
	// Destination and Tnew as seen from E
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		// No producer unless a case below says otherwise
		prod = '0;

		case (opcode)
			hazardPkg::opR: begin
				case (funct)
					hazardPkg::fnAdd, hazardPkg::fnSub, hazardPkg::fnAnd,
					hazardPkg::fnOr, hazardPkg::fnSlt, hazardPkg::fnSltu: begin
						prod.dest = rd;
						prod.tnew = 2'd1;
					end
					// Result comes out of HI/LO at the end of E
					hazardPkg::fnMfhi, hazardPkg::fnMflo: begin
						prod.dest = rd;
						prod.tnew = 2'd1;
					end
					// jr, mult/div and mthi/mtlo write no GPR
					default: prod = '0;
				endcase
			end
			hazardPkg::opOri, hazardPkg::opAddi, hazardPkg::opAndi: begin
				prod.dest = rt;
				prod.tnew = 2'd1;
			end
			hazardPkg::opLui: begin
				prod.dest = rt;
				prod.tnew = 2'd1;
			end
			// Data available only after the memory stage
			hazardPkg::opLw, hazardPkg::opLb, hazardPkg::opLh: begin
				prod.dest = rt;
				prod.tnew = 2'd2;
			end
			// Late timing but no register known here
			hazardPkg::opLwmx: begin
				prod.dest = '0;
				prod.tnew = 2'd2;
			end
			// PC+8 is ready as soon as jal leaves D
			hazardPkg::opJal: begin
				prod.dest = hazardPkg::regRa;
				prod.tnew = 2'd0;
			end
			hazardPkg::opSw, hazardPkg::opSb, hazardPkg::opSh,
			hazardPkg::opBeq, hazardPkg::opBne, hazardPkg::opJ: begin
				prod = '0;
			end
			default: prod = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- src/stageTracker.sv
`timescale 1ns/10ps
`default_nettype none

module stageTracker (
	input  wire logic              clk,
	input  wire logic              rstN,
	input  wire logic              stall,
	input  wire hazardPkg::producerT prodD,
	input  wire hazardPkg::demandT   demandD,
	output hazardPkg::stageRecT      recE,
	output hazardPkg::stageRecT      recM,
	output hazardPkg::stageRecT      recW
);

	hazardPkg::stageRecT recD;
	hazardPkg::stageRecT nextE;
	hazardPkg::stageRecT nextM;
	hazardPkg::stageRecT nextW;

	// One stage closer, stops at zero
	function automatic hazardPkg::stageCntT countDown(input hazardPkg::stageCntT cnt);
		return (cnt == 2'd0) ? 2'd0 : cnt - 2'd1;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Next-state records
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		// Unread sources go in as register 0 so they never forward
		recD.prod  = prodD;
		recD.srcRs = demandD.useRs ? demandD.rs : '0;
		recD.srcRt = demandD.useRt ? demandD.rt : '0;

		// Bubble into E while D is held
		nextE = stall ? '0 : recD;

		nextM           = recE;
		nextM.prod.tnew = countDown(recE.prod.tnew);

		nextW           = recM;
		nextW.prod.tnew = '0;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			recE <= '0;
			recM <= '0;
			recW <= '0;
		end else begin
			recE <= nextE;
			recM <= nextM;
			recW <= nextW;
		end
	end

endmodule

`default_nettype wire

//--- src/stallControl.sv
`timescale 1ns/10ps
`default_nettype none

module stallControl (
	input  wire hazardPkg::demandT   demand,
	input  wire hazardPkg::producerT prodE,
	input  wire hazardPkg::producerT prodM,
	input  wire logic                mdBusy,
	output logic                     stall
);

	logic stallRs;
	logic stallRt;
	logic stallMd;

	// Producer still too far from its result for this consumer
	function automatic logic lateProducer(
		input hazardPkg::regNumT   src,
		input hazardPkg::stageCntT tuse,
		input hazardPkg::producerT prod
	);
		return (src != '0) && (src == prod.dest) && (prod.tnew > tuse);
	endfunction

	always_comb begin
		stallRs = demand.useRs &&
			(lateProducer(demand.rs, demand.tuseRs, prodE) ||
			 lateProducer(demand.rs, demand.tuseRs, prodM));

		stallRt = demand.useRt &&
			(lateProducer(demand.rt, demand.tuseRt, prodE) ||
			 lateProducer(demand.rt, demand.tuseRt, prodM));

		// HI/LO users wait for the multiply/divide unit
		stallMd = demand.isMd && mdBusy;
	end

	assign stall = stallRs || stallRt || stallMd;

endmodule

`default_nettype wire

//--- verif/hazardUnitTb.sv
`timescale 1ns/10ps
`default_nettype none

module hazardUnitTb;

	logic        clk;
	logic        rstN;
	logic [31:0] instrD;
	logic        mdBusy;
	logic        stall;
	hazardPkg::fwdSelT fwdRsD;
	hazardPkg::fwdSelT fwdRtD;
	hazardPkg::fwdSelT fwdRsE;
	hazardPkg::fwdSelT fwdRtE;
	hazardPkg::fwdSelT fwdRtM;

	// Model pipeline records
	hazardPkg::stageRecT mE;
	hazardPkg::stageRecT mM;
	hazardPkg::stageRecT mW;

	// Outputs sampled just before the rising edge
	logic       sStall;
	logic [1:0] sRsD;
	logic [1:0] sRtD;
	logic [1:0] sRsE;
	logic [1:0] sRtE;
	logic [1:0] sRtM;

	logic [31:0] lfsr;
	int          errCount;

	hazardUnit u_dut (
		.clk    (clk),
		.rstN   (rstN),
		.instrD (instrD),
		.mdBusy (mdBusy),
		.stall  (stall),
		.fwdRsD (fwdRsD),
		.fwdRtD (fwdRtD),
		.fwdRsE (fwdRsE),
		.fwdRtE (fwdRtE),
		.fwdRtM (fwdRtM)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Instruction encoding
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] encR(input logic [5:0] fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd);
		return {hazardPkg::opR, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Reference model of the hazard rules
	//////////////////////////////////////////////////////////////////////

	// Destination and Tnew once the instruction sits in E
	function automatic hazardPkg::producerT modelProd(input logic [31:0] ins);
		hazardPkg::producerT p;
		p = '0;
		case (ins[31:26])
			hazardPkg::opR: begin
				case (ins[5:0])
					hazardPkg::fnAdd, hazardPkg::fnSub, hazardPkg::fnAnd, hazardPkg::fnOr,
					hazardPkg::fnSlt, hazardPkg::fnSltu, hazardPkg::fnMfhi,
					hazardPkg::fnMflo: p = {ins[15:11], 2'd1};
					default: p = '0;
				endcase
			end
			hazardPkg::opOri, hazardPkg::opAddi, hazardPkg::opAndi,
			hazardPkg::opLui: p = {ins[20:16], 2'd1};
			hazardPkg::opLw, hazardPkg::opLb, hazardPkg::opLh: p = {ins[20:16], 2'd2};
			hazardPkg::opLwmx: p = {5'd0, 2'd2};
			hazardPkg::opJal: p = {5'd31, 2'd0};
			default: p = '0;
		endcase
		return p;
	endfunction

	// Which fields are read, and how soon
	function automatic hazardPkg::demandT modelDemand(input logic [31:0] ins);
		hazardPkg::demandT d;
		d = '0;
		d.rs = ins[25:21];
		d.rt = ins[20:16];
		case (ins[31:26])
			hazardPkg::opR: begin
				case (ins[5:0])
					hazardPkg::fnAdd, hazardPkg::fnSub, hazardPkg::fnAnd, hazardPkg::fnOr,
					hazardPkg::fnSlt, hazardPkg::fnSltu: begin
						d.useRs = 1'b1;
						d.useRt = 1'b1;
						d.tuseRs = 2'd1;
						d.tuseRt = 2'd1;
					end
					hazardPkg::fnJr: d.useRs = 1'b1;
					hazardPkg::fnMult, hazardPkg::fnMultu, hazardPkg::fnDiv,
					hazardPkg::fnDivu: begin
						d.useRs = 1'b1;
						d.useRt = 1'b1;
						d.tuseRs = 2'd1;
						d.tuseRt = 2'd1;
						d.isMd = 1'b1;
					end
					hazardPkg::fnMthi, hazardPkg::fnMtlo: begin
						d.useRs = 1'b1;
						d.tuseRs = 2'd1;
						d.isMd = 1'b1;
					end
					hazardPkg::fnMfhi, hazardPkg::fnMflo: d.isMd = 1'b1;
					default: ;
				endcase
			end
			hazardPkg::opOri, hazardPkg::opAddi, hazardPkg::opAndi, hazardPkg::opLw,
			hazardPkg::opLb, hazardPkg::opLh, hazardPkg::opLwmx: begin
				d.useRs = 1'b1;
				d.tuseRs = 2'd1;
			end
			hazardPkg::opSw, hazardPkg::opSb, hazardPkg::opSh: begin
				d.useRs = 1'b1;
				d.useRt = 1'b1;
				d.tuseRs = 2'd1;
				d.tuseRt = 2'd2;
			end
			hazardPkg::opBeq, hazardPkg::opBne: begin
				d.useRs = 1'b1;
				d.useRt = 1'b1;
			end
			default: ;
		endcase
		return d;
	endfunction

	function automatic logic producerLate(input logic [4:0] src, input logic [1:0] tuse,
		input hazardPkg::producerT p);
		return (src != 5'd0) && (src == p.dest) && (p.tnew > tuse);
	endfunction

	function automatic logic producerReady(input logic [4:0] src, input hazardPkg::producerT p);
		return (src != 5'd0) && (src == p.dest) && (p.tnew == 2'd0);
	endfunction

	// Nearest ready stage, W always allowed
	function automatic logic [1:0] pickSource(input logic [4:0] src, input logic fromE,
		input logic fromM);
		if (fromE && producerReady(src, mE.prod))
			return hazardPkg::fwdFromE;
		if (fromM && producerReady(src, mM.prod))
			return hazardPkg::fwdFromM;
		if (producerReady(src, mW.prod))
			return hazardPkg::fwdFromW;
		return hazardPkg::fwdNone;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Checking and random numbers
	//////////////////////////////////////////////////////////////////////

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "run aborted");
	endtask

	task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errCount++;
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
			abortRun("Output mismatch against the reference model");
		end
	endtask

	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit
	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrStep(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic sampleOutputs();
		sStall = stall;
		sRsD = fwdRsD;
		sRtD = fwdRtD;
		sRsE = fwdRsE;
		sRtE = fwdRtE;
		sRtM = fwdRtM;
	endtask

	// Drive on the falling edge, check, then advance the model on the rising edge
	task automatic runCycle(input logic [31:0] instr, input logic busy);
		hazardPkg::demandT   d;
		hazardPkg::producerT p;
		hazardPkg::stageRecT nE;
		hazardPkg::stageRecT nM;
		hazardPkg::stageRecT nW;
		logic                expSt;
		logic [4:0]          rsD;
		logic [4:0]          rtD;
		@(negedge clk);
		instrD = instr;
		mdBusy = busy;
		d = modelDemand(instr);
		p = modelProd(instr);
		rsD = d.useRs ? d.rs : 5'd0;
		rtD = d.useRt ? d.rt : 5'd0;
		#4;
		sampleOutputs();
		expSt = producerLate(rsD, d.tuseRs, mE.prod) || producerLate(rsD, d.tuseRs, mM.prod) ||
			producerLate(rtD, d.tuseRt, mE.prod) || producerLate(rtD, d.tuseRt, mM.prod) ||
			(d.isMd && busy);
		checkVal("stall", sStall, expSt);
		checkVal("fwdRsD", sRsD, pickSource(rsD, 1'b1, 1'b1));
		checkVal("fwdRtD", sRtD, pickSource(rtD, 1'b1, 1'b1));
		checkVal("fwdRsE", sRsE, pickSource(mE.srcRs, 1'b0, 1'b1));
		checkVal("fwdRtE", sRtE, pickSource(mE.srcRt, 1'b0, 1'b1));
		checkVal("fwdRtM", sRtM, pickSource(mM.srcRt, 1'b0, 1'b0));
		nW = mM;
		nW.prod.tnew = 2'd0;
		nM = mE;
		if (nM.prod.tnew != 2'd0)
			nM.prod.tnew = nM.prod.tnew - 2'd1;
		nE = '0;
		if (!expSt) begin
			nE.prod = p;
			nE.srcRs = rsD;
			nE.srcRt = rtD;
		end
		@(posedge clk);
		mE = nE;
		mM = nM;
		mW = nW;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic testReset();
		repeat (4) begin
			@(negedge clk);
			#4;
			sampleOutputs();
			checkVal("stall", sStall, 1'b0);
			checkVal("fwdRsD", sRsD, hazardPkg::fwdNone);
			checkVal("fwdRtD", sRtD, hazardPkg::fwdNone);
			checkVal("fwdRsE", sRsE, hazardPkg::fwdNone);
			checkVal("fwdRtE", sRtE, hazardPkg::fwdNone);
			checkVal("fwdRtM", sRtM, hazardPkg::fwdNone);
		end
		@(negedge clk);
		rstN = 1'b1;
		runCycle(32'd0, 1'b0);
		// Late writer of register 0, then readers of it
		runCycle(encI(hazardPkg::opLw, 5'd0, 5'd0, 16'd1), 1'b0);
		runCycle(encR(hazardPkg::fnAdd, 5'd0, 5'd0, 5'd1), 1'b0);
		checkVal("stall", sStall, 1'b0);
		checkVal("fwdRsD", sRsD, hazardPkg::fwdNone);
		runCycle(encI(hazardPkg::opSw, 5'd0, 5'd0, 16'd0), 1'b0);
		checkVal("fwdRtD", sRtD, hazardPkg::fwdNone);
		runCycle(32'd0, 1'b0);
		checkVal("fwdRsE", sRsE, hazardPkg::fwdNone);
	endtask

	task automatic testAluAlu();
		runCycle(encR(hazardPkg::fnAdd, 5'd1, 5'd2, 5'd5), 1'b0);
		runCycle(encR(hazardPkg::fnAdd, 5'd5, 5'd1, 5'd6), 1'b0);
		checkVal("stall", sStall, 1'b0);
		runCycle(32'd0, 1'b0);
		checkVal("fwdRsE", sRsE, hazardPkg::fwdFromM);
		// Store data taken from W while the store is in M
		runCycle(encR(hazardPkg::fnAdd, 5'd1, 5'd2, 5'd5), 1'b0);
		runCycle(encI(hazardPkg::opSw, 5'd0, 5'd5, 16'd8), 1'b0);
		checkVal("stall", sStall, 1'b0);
		runCycle(32'd0, 1'b0);
		runCycle(32'd0, 1'b0);
		checkVal("fwdRtM", sRtM, hazardPkg::fwdFromW);
	endtask

	task automatic testLoadUse();
		logic [31:0] user;
		user = encR(hazardPkg::fnAdd, 5'd8, 5'd2, 5'd9);
		runCycle(encI(hazardPkg::opLw, 5'd1, 5'd8, 16'd4), 1'b0);
		runCycle(user, 1'b0);
		checkVal("stall", sStall, 1'b1);
		// Same word held for the retry
		runCycle(user, 1'b0);
		checkVal("stall", sStall, 1'b0);
		runCycle(32'd0, 1'b0);
		checkVal("stall", sStall, 1'b0);
		checkVal("fwdRsE", sRsE, hazardPkg::fwdFromW);
	endtask

	task automatic testBranchJump();
		logic [31:0] br;
		br = encI(hazardPkg::opBeq, 5'd3, 5'd0, 16'd4);
		runCycle(encI(hazardPkg::opOri, 5'd0, 5'd3, 16'h00ff), 1'b0);
		runCycle(br, 1'b0);
		checkVal("stall", sStall, 1'b1);
		runCycle(br, 1'b0);
		checkVal("stall", sStall, 1'b0);
		checkVal("fwdRsD", sRsD, hazardPkg::fwdFromM);
		runCycle({hazardPkg::opJal, 26'h0000040}, 1'b0);
		runCycle(encR(hazardPkg::fnJr, 5'd31, 5'd0, 5'd0), 1'b0);
		checkVal("stall", sStall, 1'b0);
		checkVal("fwdRsD", sRsD, hazardPkg::fwdFromE);
	endtask

	task automatic testMulDiv();
		logic [31:0] hiRead;
		hiRead = encR(hazardPkg::fnMfhi, 5'd0, 5'd0, 5'd4);
		runCycle(encR(hazardPkg::fnAdd, 5'd1, 5'd2, 5'd7), 1'b1);
		checkVal("stall", sStall, 1'b0);
		runCycle(hiRead, 1'b1);
		checkVal("stall", sStall, 1'b1);
		runCycle(hiRead, 1'b1);
		checkVal("stall", sStall, 1'b1);
		// Unit done, mfhi goes through in the same cycle
		runCycle(hiRead, 1'b0);
		checkVal("stall", sStall, 1'b0);
		runCycle(32'd0, 1'b0);
	endtask

	// Random pick from the decode table, registers 0 to 7
	function automatic logic [31:0] randomInstr();
		logic [31:0] bits;
		logic [4:0]  k;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [15:0] imm;
		bits = takeBits(5);
		k = bits[4:0];
		bits = takeBits(3);
		rs = {2'b00, bits[2:0]};
		bits = takeBits(3);
		rt = {2'b00, bits[2:0]};
		bits = takeBits(3);
		rd = {2'b00, bits[2:0]};
		bits = takeBits(16);
		imm = bits[15:0];
		case (k)
			5'd0:  return encR(hazardPkg::fnAdd, rs, rt, rd);
			5'd1:  return encR(hazardPkg::fnSub, rs, rt, rd);
			5'd2:  return encR(hazardPkg::fnAnd, rs, rt, rd);
			5'd3:  return encR(hazardPkg::fnOr, rs, rt, rd);
			5'd4:  return encR(hazardPkg::fnSlt, rs, rt, rd);
			5'd5:  return encR(hazardPkg::fnSltu, rs, rt, rd);
			5'd6:  return encR(hazardPkg::fnJr, rs, 5'd0, 5'd0);
			5'd7:  return encR(hazardPkg::fnMult, rs, rt, 5'd0);
			5'd8:  return encR(hazardPkg::fnMultu, rs, rt, 5'd0);
			5'd9:  return encR(hazardPkg::fnDiv, rs, rt, 5'd0);
			5'd10: return encR(hazardPkg::fnDivu, rs, rt, 5'd0);
			5'd11: return encR(hazardPkg::fnMfhi, 5'd0, 5'd0, rd);
			5'd12: return encR(hazardPkg::fnMflo, 5'd0, 5'd0, rd);
			5'd13: return encR(hazardPkg::fnMthi, rs, 5'd0, 5'd0);
			5'd14: return encR(hazardPkg::fnMtlo, rs, 5'd0, 5'd0);
			5'd15: return encI(hazardPkg::opOri, rs, rt, imm);
			5'd16: return encI(hazardPkg::opAddi, rs, rt, imm);
			5'd17: return encI(hazardPkg::opAndi, rs, rt, imm);
			5'd18: return encI(hazardPkg::opLui, 5'd0, rt, imm);
			5'd19: return encI(hazardPkg::opLw, rs, rt, imm);
			5'd20: return encI(hazardPkg::opLb, rs, rt, imm);
			5'd21: return encI(hazardPkg::opLh, rs, rt, imm);
			5'd22: return encI(hazardPkg::opSw, rs, rt, imm);
			5'd23: return encI(hazardPkg::opSb, rs, rt, imm);
			5'd24: return encI(hazardPkg::opSh, rs, rt, imm);
			5'd25: return encI(hazardPkg::opBeq, rs, rt, imm);
			5'd26: return encI(hazardPkg::opBne, rs, rt, imm);
			5'd27: return {hazardPkg::opJ, 10'd0, imm};
			5'd28: return {hazardPkg::opJal, 10'd0, imm};
			5'd29: return encI(hazardPkg::opLwmx, rs, rt, imm);
			5'd30: return encR(hazardPkg::fnAdd, rs, rt, rd);
			default: return encI(hazardPkg::opLw, rs, rt, imm);
		endcase
	endfunction

	task automatic testRandom();
		logic [31:0] w;
		logic [31:0] bits;
		logic        busy;
		int          waitCnt;
		for (int n = 0; n < 400; n++) begin
			w = randomInstr();
			waitCnt = 0;
			bits = takeBits(1);
			busy = bits[0];
			runCycle(w, busy);
			// Hold the word while the DUT stalls
			while (sStall) begin
				waitCnt++;
				if (waitCnt > 40)
					abortRun("Timed out waiting for a random instruction to leave D");
				else begin
					bits = takeBits(1);
					busy = bits[0];
					runCycle(w, busy);
				end
			end
		end
	endtask

	initial begin
		rstN = 1'b0;
		instrD = '0;
		mdBusy = 1'b0;
		lfsr = 32'hc4e1_4323;
		errCount = 0;
		mE = '0;
		mM = '0;
		mW = '0;
		testReset();
		testAluAlu();
		testLoadUse();
		testBranchJump();
		testMulDiv();
		testRandom();
		if (errCount == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
src/hazardPkg.sv
src/demandDecoder.sv
src/producerDecoder.sv
src/stageTracker.sv
src/stallControl.sv
src/forwardSelect.sv
src/hazardUnit.sv
verif/hazardUnitTb.sv
